// ==== compile.f ====
common/otp_part_pkg.sv
hw/otp_part_addr.sv
hw/otp_part_lock.sv
part_fsm/otp_part_fsm.sv
hw/otp_part_unbuf.sv
test/tb_otp_part_unbuf.sv

// ==== Makefile ====
# Verilator build and run for the OTP partition testbench

VERILATOR ?= verilator
TOP       := tb_otp_part_unbuf
FILELIST  := compile.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_otp_part_unbuf.sv ====
// Self-checking random testbench that drives the OTP partition through init, reads, locks and errors
`timescale 1ns/1ps
`default_nettype none

module tb_otp_part_unbuf;
  import otp_part_pkg::*;

  localparam int WaitLimit = 200;
  // Bus word window of the partition
  localparam int unsigned WordBytes = BusDataWidth / 8;
  localparam int unsigned FirstWord = PartOffset / WordBytes;
  localparam int unsigned PartWords = PartSize / WordBytes;
  // Digest sits in the last 8 bytes of a halfword addressed OTP
  localparam int unsigned DigestWordAddr = (PartOffset + PartSize - 8) / (OtpWidth / 8);

  logic clk_i;
  logic rst_ni;
  logic init_req_i;
  logic init_done_o;
  logic escalate_en_i;
  otp_err_e error_o;
  logic fsm_err_o;
  logic read_lock_i;
  logic write_lock_i;
  logic read_lock_o;
  logic write_lock_o;
  logic [ScrmblBlockWidth-1:0] digest_o;
  logic tlul_req_i;
  logic tlul_gnt_o;
  logic [SwWindowAddrWidth-1:0] tlul_addr_i;
  logic [1:0] tlul_rerror_o;
  logic tlul_rvalid_o;
  logic [BusDataWidth-1:0] tlul_rdata_o;
  logic otp_req_o;
  logic [OtpAddrWidth-1:0] otp_addr_o;
  logic [OtpSizeWidth-1:0] otp_size_o;
  logic otp_gnt_i;
  logic otp_rvalid_i;
  logic [ScrmblBlockWidth-1:0] otp_rdata_i;
  otp_err_e otp_err_i;

  // OTP macro contents in halfwords
  logic [OtpWidth-1:0] otp_mem [2**OtpAddrWidth];

  // Reference model state
  otp_err_e exp_error;
  logic terminal;
  logic [ScrmblBlockWidth-1:0] digest_model;
  logic rl_model;
  logic wl_model;

  otp_part_unbuf otp_part_unbuf_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////
  // Helpers
  //////////////////////

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("FAILED at %0t ns: %s expected %0h actual %0h", $time, name, exp, act);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns, no %s within %0d cycles", $time, what, WaitLimit);
    $display("Test failed");
    $fatal(1, "timeout");
  endtask

  // Registered locks of an initialized partition against the model
  task automatic check_locks();
    check_value("read_lock_o", 64'(rl_model || digest_model != '0), 64'(read_lock_o));
    check_value("write_lock_o", 64'(wl_model || digest_model != '0), 64'(write_lock_o));
  endtask

  // Macro block read where size is the number of halfwords minus one
  function automatic logic [63:0] mem_block(input logic [OtpAddrWidth-1:0] addr,
                                            input logic [OtpSizeWidth-1:0] size);
    logic [63:0] blk;
    int i;
    blk = '0;
    for (i = 0; i <= int'(size); i++) begin
      blk[16*i +: 16] = otp_mem[OtpAddrWidth'(int'(addr) + i)];
    end
    return blk;
  endfunction

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni        <= 1'b0;
    init_req_i    <= 1'b0;
    escalate_en_i <= 1'b0;
    read_lock_i   <= 1'b0;
    write_lock_i  <= 1'b0;
    tlul_req_i    <= 1'b0;
    tlul_addr_i   <= '0;
    otp_gnt_i     <= 1'b0;
    otp_rvalid_i  <= 1'b0;
    otp_rdata_i   <= '0;
    otp_err_i     <= NoError;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    exp_error    = NoError;
    terminal     = 1'b0;
    digest_model = '0;
    rl_model     = 1'b0;
    wl_model     = 1'b0;
  endtask

  // Macro responder that starts at a negedge and returns at the negedge of the rvalid cycle
  task automatic otp_respond(input int unsigned exp_addr, input int unsigned exp_size,
                             input otp_err_e err);
    int cnt;
    int unsigned gnt_delay;
    int unsigned rsp_delay;
    logic [OtpAddrWidth-1:0] seen_addr;
    logic [63:0] blk;
    cnt = 0;
    gnt_delay = $urandom_range(0, 5);
    rsp_delay = $urandom_range(0, 5);
    while (!otp_req_o) begin
      cnt++;
      assert (cnt < WaitLimit) else report_timeout("OTP request");
      @(negedge clk_i);
    end
    seen_addr = otp_addr_o;
    check_value("otp_addr_o", 64'(exp_addr), 64'(otp_addr_o));
    check_value("otp_size_o", 64'(exp_size), 64'(otp_size_o));
    blk = mem_block(otp_addr_o, otp_size_o);
    repeat (gnt_delay) @(posedge clk_i);
    @(posedge clk_i);
    otp_gnt_i <= 1'b1;
    @(negedge clk_i);
    // Request has to stay put until granted
    check_value("otp_req_o", 64'(1), 64'(otp_req_o));
    check_value("otp_addr_o", 64'(seen_addr), 64'(otp_addr_o));
    @(posedge clk_i);
    otp_gnt_i <= 1'b0;
    repeat (rsp_delay) @(posedge clk_i);
    otp_rvalid_i <= 1'b1;
    otp_rdata_i  <= blk;
    otp_err_i    <= err;
    @(negedge clk_i);
  endtask

  task automatic run_init(input logic [63:0] digest);
    int i;
    for (i = 0; i < 4; i++) begin
      otp_mem[DigestWordAddr + i] = digest[16*i +: 16];
    end
    @(negedge clk_i);
    // Uninitialized out of reset
    check_value("read_lock_o", 64'(1), 64'(read_lock_o));
    check_value("write_lock_o", 64'(1), 64'(write_lock_o));
    check_value("init_done_o", 64'(0), 64'(init_done_o));
    check_value("digest_o", 64'(0), digest_o);
    check_value("error_o", 64'(NoError), 64'(error_o));
    check_value("otp_req_o", 64'(0), 64'(otp_req_o));
    check_value("tlul_gnt_o", 64'(0), 64'(tlul_gnt_o));
    check_value("tlul_rvalid_o", 64'(0), 64'(tlul_rvalid_o));
    @(posedge clk_i);
    init_req_i <= 1'b1;
    @(posedge clk_i);
    init_req_i <= 1'b0;
    @(negedge clk_i);
    check_value("otp_req_o", 64'(1), 64'(otp_req_o));
    otp_respond(DigestWordAddr, ScrmblBlockWidth / OtpWidth - 1, NoError);
    check_value("init_done_o", 64'(0), 64'(init_done_o));
    @(posedge clk_i);
    otp_rvalid_i <= 1'b0;
    @(negedge clk_i);
    check_value("init_done_o", 64'(1), 64'(init_done_o));
    check_value("digest_o", digest, digest_o);
    digest_model = digest;
    // Locks are registered once more
    @(negedge clk_i);
    check_locks();
  endtask

  task automatic bus_read(input logic [SwWindowAddrWidth-1:0] addr, input otp_err_e err);
    int cnt;
    int unsigned word;
    logic in_range;
    logic direct_err;
    logic [1:0] exp_rerror;
    logic [31:0] exp_data;
    word       = int'(addr);
    in_range   = (word >= FirstWord) && (word < FirstWord + PartWords);
    direct_err = terminal || !in_range || rl_model || (digest_model != '0);
    @(posedge clk_i);
    tlul_req_i  <= 1'b1;
    tlul_addr_i <= addr;
    cnt = 0;
    @(negedge clk_i);
    while (!tlul_gnt_o) begin
      cnt++;
      assert (cnt < WaitLimit) else report_timeout("bus grant");
      @(negedge clk_i);
    end
    // Grant is due in the request cycle
    check_value("tlul_gnt_o latency", 64'(0), 64'(cnt));
    @(posedge clk_i);
    tlul_req_i <= 1'b0;
    @(negedge clk_i);
    // The grant clears soft errors
    check_value("error_o", 64'(terminal ? exp_error : NoError), 64'(error_o));
    if (direct_err) begin
      check_value("otp_req_o", 64'(0), 64'(otp_req_o));
    end else begin
      check_value("tlul_rvalid_o", 64'(0), 64'(tlul_rvalid_o));
      otp_respond(word * WordBytes / (OtpWidth / 8), BusDataWidth / OtpWidth - 1, err);
    end
    if (direct_err || !(err inside {NoError, MacroEccCorrError})) begin
      exp_rerror = BusErr;
      exp_data   = '0;
    end else begin
      exp_rerror = 2'b00;
      exp_data   = {otp_mem[2*word+1], otp_mem[2*word]};
    end
    check_value("tlul_rvalid_o", 64'(1), 64'(tlul_rvalid_o));
    check_value("tlul_rerror_o", 64'(exp_rerror), 64'(tlul_rerror_o));
    check_value("tlul_rdata_o", 64'(exp_data), 64'(tlul_rdata_o));
    // Model error update, terminal errors stick
    if (!terminal) begin
      if (direct_err) begin
        exp_error = AccessError;
      end else begin
        exp_error = err;
        terminal  = !(err inside {NoError, MacroEccCorrError});
      end
    end
    @(posedge clk_i);
    otp_rvalid_i <= 1'b0;
    @(negedge clk_i);
    check_value("tlul_rvalid_o", 64'(0), 64'(tlul_rvalid_o));
    check_value("error_o", 64'(exp_error), 64'(error_o));
  endtask

  //////////////////////
  // Sequence
  //////////////////////

  initial begin
    logic [SwWindowAddrWidth-1:0] addr;
    otp_err_e err;
    int i;
    void'($urandom(32'h2910));
    rst_ni        = 1'b0;
    init_req_i    = 1'b0;
    escalate_en_i = 1'b0;
    read_lock_i   = 1'b0;
    write_lock_i  = 1'b0;
    tlul_req_i    = 1'b0;
    tlul_addr_i   = '0;
    otp_gnt_i     = 1'b0;
    otp_rvalid_i  = 1'b0;
    otp_rdata_i   = '0;
    otp_err_i     = NoError;
    // Pattern covers all ten address bits
    for (i = 0; i < 2**OtpAddrWidth; i++) begin
      otp_mem[i] = {i[5:0], i[9:0]} ^ 16'h3c5a;
    end

    // Random reads over a zero digest with some correctable ECC hits
    apply_reset();
    run_init('0);
    repeat (200) begin
      if ($urandom_range(0, 3) != 0) begin
        addr = SwWindowAddrWidth'(FirstWord + $urandom_range(0, PartWords - 1));
      end else begin
        addr = SwWindowAddrWidth'($urandom_range(0, 2**SwWindowAddrWidth - 1));
      end
      err = ($urandom_range(0, 7) == 0) ? MacroEccCorrError : NoError;
      bus_read(addr, err);
    end
    bus_read(SwWindowAddrWidth'(FirstWord + 4), MacroEccCorrError);
    bus_read(SwWindowAddrWidth'(FirstWord + 5), NoError);

    // Write lock alone leaves reads open
    @(posedge clk_i);
    write_lock_i <= 1'b1;
    wl_model = 1'b1;
    @(negedge clk_i);
    // One register stage, nothing moves yet
    check_value("write_lock_o", 64'(0), 64'(write_lock_o));
    @(negedge clk_i);
    check_locks();
    bus_read(SwWindowAddrWidth'(FirstWord + 3), NoError);

    // Read lock blocks every read
    @(posedge clk_i);
    read_lock_i <= 1'b1;
    rl_model = 1'b1;
    @(negedge clk_i);
    check_value("read_lock_o", 64'(0), 64'(read_lock_o));
    @(negedge clk_i);
    check_locks();
    repeat (4) bus_read(SwWindowAddrWidth'(FirstWord + $urandom_range(0, PartWords - 1)), NoError);
    @(posedge clk_i);
    read_lock_i  <= 1'b0;
    write_lock_i <= 1'b0;
    rl_model = 1'b0;
    wl_model = 1'b0;
    @(negedge clk_i);
    @(negedge clk_i);
    check_locks();
    bus_read(SwWindowAddrWidth'(FirstWord + 2), NoError);

    // Nonzero digest locks the partition
    apply_reset();
    run_init({32'($urandom), 32'($urandom)} | 64'h1);
    repeat (20) bus_read(SwWindowAddrWidth'($urandom_range(0, 63)), NoError);

    // Hard macro error is terminal
    apply_reset();
    run_init('0);
    err = ($urandom_range(0, 1) != 0) ? MacroEccUncorrError : MacroError;
    bus_read(SwWindowAddrWidth'(FirstWord + 1), err);
    check_value("fsm_err_o", 64'(0), 64'(fsm_err_o));
    repeat (10) bus_read(SwWindowAddrWidth'($urandom_range(0, 63)), NoError);

    // Escalation
    apply_reset();
    run_init('0);
    bus_read(SwWindowAddrWidth'(FirstWord + 9), NoError);
    @(posedge clk_i);
    escalate_en_i <= 1'b1;
    @(negedge clk_i);
    check_value("fsm_err_o", 64'(1), 64'(fsm_err_o));
    @(posedge clk_i);
    escalate_en_i <= 1'b0;
    @(negedge clk_i);
    check_value("fsm_err_o", 64'(0), 64'(fsm_err_o));
    check_value("error_o", 64'(FsmStateError), 64'(error_o));
    exp_error = FsmStateError;
    terminal  = 1'b1;
    repeat (10) bus_read(SwWindowAddrWidth'($urandom_range(0, 63)), NoError);

    $display("Test passed");
    $finish;
  end

endmodule : tb_otp_part_unbuf

`default_nettype wire

// ==== hw/otp_part_unbuf.sv ====
// Top of the unbuffered read-only OTP partition, connects the bus window and the OTP macro port
`timescale 1ns/1ps
`default_nettype none

module otp_part_unbuf (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Init handshake, once per power cycle
  input  logic                                          init_req_i,
  output logic                                          init_done_o,
  // Escalation moves the partition into its terminal state
  input  logic                                          escalate_en_i,
  output otp_part_pkg::otp_err_e                        error_o,
  output logic                                          fsm_err_o,
  // Runtime locks in, aggregated locks out
  input  logic                                          read_lock_i,
  input  logic                                          write_lock_i,
  output logic                                          read_lock_o,
  output logic                                          write_lock_o,
  output logic [otp_part_pkg::ScrmblBlockWidth-1:0]     digest_o,
  // Bus window
  input  logic                                          tlul_req_i,
  output logic                                          tlul_gnt_o,
  input  logic [otp_part_pkg::SwWindowAddrWidth-1:0]    tlul_addr_i,
  output logic [1:0]                                    tlul_rerror_o,
  output logic                                          tlul_rvalid_o,
  output logic [otp_part_pkg::BusDataWidth-1:0]         tlul_rdata_o,
  // OTP macro
  output logic                                          otp_req_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0]         otp_addr_o,
  output logic [otp_part_pkg::OtpSizeWidth-1:0]         otp_size_o,
  input  logic                                          otp_gnt_i,
  input  logic                                          otp_rvalid_i,
  input  logic [otp_part_pkg::ScrmblBlockWidth-1:0]     otp_rdata_i,
  input  otp_part_pkg::otp_err_e                        otp_err_i
);

  // Address select, high picks the bus data address
  logic addr_sel;
  // Latch strobe for the bus address, same cycle as the grant
  logic addr_capture;
  logic addr_in_range;
  // Digest register write enable
  logic digest_wr;

  // Control FSM, also returns read data on the bus
  otp_part_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .init_req_i      (init_req_i),
    .escalate_en_i   (escalate_en_i),
    .otp_gnt_i       (otp_gnt_i),
    .otp_rvalid_i    (otp_rvalid_i),
    .otp_rdata_i     (otp_rdata_i),
    .otp_err_i       (otp_err_i),
    .tlul_req_i      (tlul_req_i),
    .addr_in_range_i (addr_in_range),
    .read_lock_i     (read_lock_o),
    .init_done_o     (init_done_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .otp_req_o       (otp_req_o),
    .addr_sel_o      (addr_sel),
    .addr_capture_o  (addr_capture),
    .digest_wr_o     (digest_wr),
    .tlul_gnt_o      (tlul_gnt_o),
    .tlul_rvalid_o   (tlul_rvalid_o),
    .tlul_rerror_o   (tlul_rerror_o),
    .tlul_rdata_o    (tlul_rdata_o)
  );

  // Range check and OTP address formation
  otp_part_addr u_addr (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .tlul_addr_i     (tlul_addr_i),
    .addr_capture_i  (addr_capture),
    .addr_sel_i      (addr_sel),
    .addr_in_range_o (addr_in_range),
    .otp_addr_o      (otp_addr_o),
    .otp_size_o      (otp_size_o)
  );

  // Digest storage and lock aggregation
  otp_part_lock u_lock (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .digest_wr_i  (digest_wr),
    .otp_rdata_i  (otp_rdata_i),
    .init_done_i  (init_done_o),
    .read_lock_i  (read_lock_i),
    .write_lock_i (write_lock_i),
    .digest_o     (digest_o),
    .read_lock_o  (read_lock_o),
    .write_lock_o (write_lock_o)
  );

endmodule : otp_part_unbuf

`default_nettype wire

// ==== part_fsm/otp_part_fsm.sv ====
// Partition control FSM, sequences digest init and bus reads against the OTP macro and latches errors
`timescale 1ns/1ps
`default_nettype none

module otp_part_fsm (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      init_req_i,
  input  logic                                      escalate_en_i,
  input  logic                                      otp_gnt_i,
  input  logic                                      otp_rvalid_i,
  input  logic [otp_part_pkg::ScrmblBlockWidth-1:0] otp_rdata_i,
  input  otp_part_pkg::otp_err_e                    otp_err_i,
  input  logic                                      tlul_req_i,
  input  logic                                      addr_in_range_i,
  input  logic                                      read_lock_i,
  output logic                                      init_done_o,
  output otp_part_pkg::otp_err_e                    error_o,
  output logic                                      fsm_err_o,
  output logic                                      otp_req_o,
  output logic                                      addr_sel_o,
  output logic                                      addr_capture_o,
  output logic                                      digest_wr_o,
  output logic                                      tlul_gnt_o,
  output logic                                      tlul_rvalid_o,
  output logic [1:0]                                tlul_rerror_o,
  output logic [otp_part_pkg::BusDataWidth-1:0]     tlul_rdata_o
);
  import otp_part_pkg::*;

  // Code 3'h7 is unused and lands in the default branch
  typedef enum logic [2:0] {
    ResetSt    = 3'h0,
    InitSt     = 3'h1,
    InitWaitSt = 3'h2,
    IdleSt     = 3'h3,
    ReadSt     = 3'h4,
    ReadWaitSt = 3'h5,
    ErrorSt    = 3'h6
  } state_e;

  state_e   state_d, state_q;
  otp_err_e error_d, error_q;
  // Macro error after integrity filtering
  otp_err_e otp_err;
  // Granted request still owed a bus error
  logic     pending_d, pending_q;

  assign error_o = error_q;
  // Bus address is latched on every grant
  assign addr_capture_o = tlul_gnt_o;

  // ECC codes mean nothing without integrity, drop them
  always_comb begin
    if (!PartIntegrity && (otp_err_i inside {MacroEccCorrError, MacroEccUncorrError})) begin
      otp_err = NoError;
    end else begin
      otp_err = otp_err_i;
    end
  end

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d       = state_q;
    error_d       = error_q;
    pending_d     = 1'b0;
    init_done_o   = 1'b0;
    fsm_err_o     = 1'b0;
    otp_req_o     = 1'b0;
    // Digest address unless a data read is requested
    addr_sel_o    = 1'b0;
    digest_wr_o   = 1'b0;
    tlul_gnt_o    = 1'b0;
    tlul_rvalid_o = 1'b0;
    tlul_rerror_o = 2'b00;

    case (state_q)
      // Wait for the init pulse
      ResetSt: begin
        if (init_req_i) begin
          // Without a digest there is nothing to fetch
          state_d = PartSwDigest ? InitSt : IdleSt;
        end
      end
      // Digest fetch, hold the request until granted
      InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = InitWaitSt;
        end
      end
      // Store the digest and sort the response code
      InitWaitSt: begin
        if (otp_rvalid_i) begin
          digest_wr_o = 1'b1;
          if (otp_err inside {NoError, MacroEccCorrError}) begin
            state_d = IdleSt;
            // Correctable ECC is only a soft error
            if (otp_err != NoError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            state_d = ErrorSt;
            error_d = otp_err;
          end
        end
      end
      // Grant in the request cycle
      IdleSt: begin
        init_done_o = 1'b1;
        if (tlul_req_i) begin
          tlul_gnt_o = 1'b1;
          // A new access clears soft errors
          error_d    = NoError;
          state_d    = ReadSt;
        end
      end
      // Range and lock check, then request two OTP words
      ReadSt: begin
        init_done_o = 1'b1;
        if (addr_in_range_i && !read_lock_i) begin
          otp_req_o  = 1'b1;
          addr_sel_o = 1'b1;
          if (otp_gnt_i) begin
            state_d = ReadWaitSt;
          end
        end else begin
          // Bus error only, the partition stays usable
          tlul_rvalid_o = 1'b1;
          tlul_rerror_o = BusErr;
          error_d       = AccessError;
          state_d       = IdleSt;
        end
      end
      // Response goes out with the OTP data
      ReadWaitSt: begin
        init_done_o = 1'b1;
        if (otp_rvalid_i) begin
          tlul_rvalid_o = 1'b1;
          if (otp_err inside {NoError, MacroEccCorrError}) begin
            state_d = IdleSt;
            if (otp_err != NoError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            tlul_rerror_o = BusErr;
            error_d       = otp_err;
            state_d       = ErrorSt;
          end
        end
      end
      // Terminal, every request is answered with a bus error
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
        if (pending_q) begin
          tlul_rvalid_o = 1'b1;
          tlul_rerror_o = BusErr;
        end else if (tlul_req_i) begin
          tlul_gnt_o = 1'b1;
          pending_d  = 1'b1;
        end
      end
      // Illegal encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides whatever the case decided
    if (escalate_en_i) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (state_q != ErrorSt) begin
        error_d   = FsmStateError;
        // An access granted but not yet answered is answered from ErrorSt
        pending_d = tlul_gnt_o ||
                    ((state_q inside {ReadSt, ReadWaitSt}) && !tlul_rvalid_o);
      end
    end
  end

  // Data only on a clean response
  assign tlul_rdata_o = (tlul_rvalid_o && tlul_rerror_o == 2'b00) ?
                        otp_rdata_i[BusDataWidth-1:0] : '0;

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ResetSt;
      error_q   <= NoError;
      pending_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      error_q   <= error_d;
      pending_q <= pending_d;
    end
  end

endmodule : otp_part_fsm

`default_nettype wire

// ==== hw/otp_part_lock.sv ====
// Digest register and lock aggregation for the partition, read lock is also consumed by the FSM
`timescale 1ns/1ps
`default_nettype none

module otp_part_lock (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      digest_wr_i,
  input  logic [otp_part_pkg::ScrmblBlockWidth-1:0] otp_rdata_i,
  input  logic                                      init_done_i,
  input  logic                                      read_lock_i,
  input  logic                                      write_lock_i,
  output logic [otp_part_pkg::ScrmblBlockWidth-1:0] digest_o,
  output logic                                      read_lock_o,
  output logic                                      write_lock_o
);
  import otp_part_pkg::*;

  // Nonzero digest means the partition has been locked down
  logic digest_locked;
  logic read_lock_d;
  logic write_lock_d;

  assign digest_locked = (digest_o != '0);

  // Uninitialized, runtime lock or digest lock
  assign read_lock_d  = !init_done_i || read_lock_i || (PartReadLock && digest_locked);
  assign write_lock_d = !init_done_i || write_lock_i || (PartWriteLock && digest_locked);

  // Locks come out of reset set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_o     <= '0;
      read_lock_o  <= 1'b1;
      write_lock_o <= 1'b1;
    end else begin
      if (digest_wr_i) begin
        digest_o <= otp_rdata_i;
      end
      read_lock_o  <= read_lock_d;
      write_lock_o <= write_lock_d;
    end
  end

endmodule : otp_part_lock

`default_nettype wire

// ==== hw/otp_part_addr.sv ====
// Bus address holder for the partition, range check and OTP word address and size generation
`timescale 1ns/1ps
`default_nettype none

module otp_part_addr (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic [otp_part_pkg::SwWindowAddrWidth-1:0] tlul_addr_i,
  input  logic                                       addr_capture_i,
  // High selects the bus address, low the digest
  input  logic                                       addr_sel_i,
  output logic                                       addr_in_range_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0]      otp_addr_o,
  output logic [otp_part_pkg::OtpSizeWidth-1:0]      otp_size_o
);
  import otp_part_pkg::*;

  logic [SwWindowAddrWidth-1:0] tlul_addr_q;
  // Byte address of the granted word
  logic [OtpByteAddrWidth-1:0]  byte_addr;
  // Zero extended to compare against the partition end
  logic [OtpByteAddrWidth:0]    byte_addr_ext;
  logic [OtpByteAddrWidth-1:0]  addr_calc;

  // Address taken on the grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tlul_addr_q <= '0;
    end else if (addr_capture_i) begin
      tlul_addr_q <= tlul_addr_i;
    end
  end

  assign byte_addr     = {tlul_addr_q, 2'b00};
  assign byte_addr_ext = {1'b0, byte_addr};

  // Inside [PartOffset, PartEnd)
  assign addr_in_range_o = (byte_addr_ext >= (OtpByteAddrWidth + 1)'(PartOffset)) &&
                           (byte_addr_ext < PartEnd);

  assign addr_calc = addr_sel_i ? byte_addr : DigestOffset;

  // OTP is halfword addressed
  assign otp_addr_o = addr_calc[OtpByteAddrWidth-1:OtpAddrShift];

  // Full 64-bit block for the digest, one bus word for data
  assign otp_size_o = addr_sel_i ? OtpSizeWidth'(BusDataWidth / OtpWidth - 1) :
                                   OtpSizeWidth'(ScrmblBlockWidth / OtpWidth - 1);

endmodule : otp_part_addr

`default_nettype wire

// ==== common/otp_part_pkg.sv ====
// Shared error codes, widths and partition geometry, imported by all partition RTL and the testbench
`default_nettype none

package otp_part_pkg;

  ////////////////////
  // Error codes
  ////////////////////

  // Same encoding on the OTP macro error input and on the partition error output
  typedef enum logic [2:0] {
    NoError              = 3'h0,
    MacroError           = 3'h1,
    MacroEccCorrError    = 3'h2,
    MacroEccUncorrError  = 3'h3,
    MacroWriteBlankError = 3'h4,
    AccessError          = 3'h5,
    CheckFailError       = 3'h6,
    FsmStateError        = 3'h7
  } otp_err_e;

  ////////////////////
  // Widths
  ////////////////////

  // Digest and OTP read data width
  localparam int unsigned ScrmblBlockWidth = 64;
  // Software bus read data
  localparam int unsigned BusDataWidth = 32;
  // Native OTP word, a halfword
  localparam int unsigned OtpWidth = 16;
  localparam int unsigned OtpByteAddrWidth = 11;
  // Byte address to halfword address
  localparam int unsigned OtpAddrShift = 1;
  localparam int unsigned OtpAddrWidth = OtpByteAddrWidth - OtpAddrShift;
  // Number of OTP words minus one
  localparam int unsigned OtpSizeWidth = 2;
  // Bus word address into the window
  localparam int unsigned SwWindowAddrWidth = 9;

  ////////////////////
  // Partition geometry
  ////////////////////

  // Start and size in bytes, digest sits in the last 8 bytes
  localparam int unsigned PartOffset = 64;
  localparam int unsigned PartSize = 64;

  // One bit wider than a byte address so the end can be represented
  localparam logic [OtpByteAddrWidth:0] PartEnd =
      (OtpByteAddrWidth + 1)'(PartOffset + PartSize);

  localparam logic [OtpByteAddrWidth-1:0] DigestOffset =
      OtpByteAddrWidth'(PartEnd - ScrmblBlockWidth / 8);

  // Partition features
  localparam bit PartSwDigest = 1'b1;
  localparam bit PartReadLock = 1'b1;
  localparam bit PartWriteLock = 1'b1;
  localparam bit PartIntegrity = 1'b1;

  // Bus adapter turns this response code into a bus error
  localparam logic [1:0] BusErr = 2'b11;

endpackage : otp_part_pkg

`default_nettype wire
